//--- build.sh
#!/bin/sh
# Compile and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
	--top-module cpuControlTb -f cpuControl.f

# The run stops on the first error, so its status is not used here
./obj_dir/VcpuControlTb > sim.log 2>&1 || true
cat sim.log

if grep -q "^sim passed$" sim.log; then
	exit 0
else
	echo "Simulation did not pass"
	exit 1
fi

//--- cpuControl.f
source/controlPkg.sv
source/interruptController.sv
source/flagRegister.sv
source/sequencer.sv
source/datapathDecoder.sv
source/memoryBusDecoder.sv
source/cpuControl.sv
tests/cpuControlTb.sv

//--- source/controlPkg.sv
// CPU control definitions
`default_nettype none

package controlPkg;

	localparam int flagWidth = 4;
	localparam int opcodeWidth = 5;
	localparam int branchWidth = 3;

	// Status register bit positions
	localparam int flagZ = 0;
	localparam int flagC = 1;
	localparam int flagV = 2;
	localparam int flagN = 3;

	typedef enum logic [opcodeWidth-1:0] {
		ADD, ADDI, ADDIB, ADC, ADCI, SUB, SUBI, SUBIB, SUC, SUCI,
		LUI, LLI, CMP, CMPI, AND, OR, XOR, NOT, NAND, NOR,
		LSL, LSR, ASR, NEG, BRANCH, INTERRUPT, LDW, STW, PUSH, POP
	} opcode_t;

	typedef enum logic [branchWidth-1:0] {
		BR, BNE, BE, BLT, BGE, BWL, RET, JMP
	} branch_t;

	// INTERRUPT sub-codes share the branch field
	localparam logic [branchWidth-1:0] intEnableCode = 3'd1;
	localparam logic [branchWidth-1:0] intDisableCode = 3'd2;

	typedef enum logic [1:0] {fetch, execute, interrupt} state_t;
	typedef enum logic [2:0] {cycle0, cycle1, cycle2, cycle3, cycle4} stateSub_t;

	typedef struct packed {
		state_t state;
		stateSub_t stateSub;
	} phase_t;

	// Opcode in bits 7:3, branch code in 2:0
	typedef struct packed {
		opcode_t opcode;
		branch_t branch;
	} instr_t;

	// First member of each select is the idle choice
	typedef enum logic {Op1Rd1, Op1Pc} op1Sel_t;
	typedef enum logic [1:0] {Op2Imm, Op2Rd2, Op2Zero} op2Sel_t;
	typedef enum logic {ImmLong, ImmShort} immSel_t;
	typedef enum logic [1:0] {Rs1Ra, Rs1Rd, Rs1Seven} rs1Sel_t;
	typedef enum logic [1:0] {RwRd, RwRa, RwSeven} rwSel_t;
	typedef enum logic {WdAlu, WdSys} wdSel_t;
	typedef enum logic [1:0] {Pc1, PcAluOut, PcSysbus, PcInt} pcSel_t;
	typedef enum logic {LrSys, LrPc} lrSel_t;
	typedef enum logic [1:0] {NoOr, AddOr, SubOr} aluOr_t;

	typedef struct packed {
		logic AluEn;
		logic AluWe;
		logic LrEn;
		logic LrWe;
		logic PcEn;
		logic PcWe;
		logic IrWe;
		logic RegWe;
		op1Sel_t Op1Sel;
		op2Sel_t Op2Sel;
		immSel_t ImmSel;
		rs1Sel_t Rs1Sel;
		rwSel_t RwSel;
		wdSel_t WdSel;
		pcSel_t PcSel;
		lrSel_t LrSel;
		aluOr_t AluOr;
	} datapathCtrl_t;

	typedef struct packed {
		logic ALE;
		logic nME;
		logic nOE;
		logic nWE;
		logic MemEn;
		logic ENB;
	} busCtrl_t;

endpackage

`default_nettype wire

//--- source/cpuControl.sv
// CPU control unit top level
`timescale 1ns/1ps
`default_nettype none

module cpuControl (
	input wire Clock,
	input wire nReset,
	input wire controlPkg::instr_t Instr,
	input wire [controlPkg::flagWidth-1:0] Flags,
	input wire nIRQ,
	input wire nWait,
	output controlPkg::datapathCtrl_t Datapath,
	output controlPkg::busCtrl_t Bus,
	output logic [controlPkg::flagWidth-1:0] StatusReg,
	output logic CFlag
);
	import controlPkg::*;

	phase_t phase;
	logic intReq;
	logic intEnable;
	logic intDisable;
	logic statusWe;
	logic branchTaken;

	interruptController i_interruptController (
		.Clock(Clock), .nReset(nReset),
		.nIRQ(nIRQ),
		.IntEnable(intEnable), .IntDisable(intDisable),
		.IntReq(intReq)
	);

	flagRegister i_flagRegister (
		.Clock(Clock), .nReset(nReset),
		.Flags(Flags), .StatusWe(statusWe), .Instr(Instr),
		.StatusReg(StatusReg), .CFlag(CFlag), .BranchTaken(branchTaken)
	);

	sequencer i_sequencer (
		.Clock(Clock), .nReset(nReset),
		.Instr(Instr), .nWait(nWait), .IntReq(intReq),
		.Phase(phase)
	);

	datapathDecoder i_datapathDecoder (
		.Phase(phase), .Instr(Instr), .BranchTaken(branchTaken), .nWait(nWait),
		.Datapath(Datapath), .StatusWe(statusWe),
		.IntEnable(intEnable), .IntDisable(intDisable)
	);

	memoryBusDecoder i_memoryBusDecoder (
		.Phase(phase), .Instr(Instr),
		.Bus(Bus)
	);

endmodule

`default_nettype wire

//--- source/datapathDecoder.sv
// Datapath select and enable decode
`timescale 1ns/1ps
`default_nettype none

module datapathDecoder (
	input wire controlPkg::phase_t Phase,
	input wire controlPkg::instr_t Instr,
	input wire BranchTaken,
	input wire nWait,
	output controlPkg::datapathCtrl_t Datapath,
	output logic StatusWe,
	output logic IntEnable,
	output logic IntDisable
);
	import controlPkg::*;

	always_comb begin
		Datapath = '0; // All enables low, every select on its idle choice
		StatusWe = 1'b0;
		IntEnable = 1'b0;
		IntDisable = 1'b0;
		case (Phase.state)
			fetch: begin
				Datapath.PcEn = Phase.stateSub != cycle2;
				Datapath.IrWe = Phase.stateSub == cycle2; // Instruction byte valid
			end
			execute: begin
				case (Phase.stateSub)
					cycle4: begin
						case (Instr.opcode)
							ADD, ADDI, ADDIB, ADC, ADCI, SUB, SUBI, SUBIB, SUC, SUCI, CMP, CMPI,
							AND, OR, XOR, NOT, NAND, NOR, LSL, LSR, ASR, NEG: begin
								Datapath.PcEn = 1'b1;
								Datapath.PcWe = 1'b1;
								Datapath.RegWe = !(Instr.opcode inside {CMP, CMPI}); // Flags only
								StatusWe = 1'b1;
								if (Instr.opcode inside {ADD, SUB, AND, OR, XOR, NAND, NOR, CMP})
									Datapath.Op2Sel = Op2Rd2;
								if (Instr.opcode inside {ADDI, SUBI, LSL, LSR, ASR, CMPI})
									Datapath.ImmSel = ImmShort;
								if (Instr.opcode inside {ADDIB, SUBIB})
									Datapath.Rs1Sel = Rs1Rd;
							end
							LUI, LLI: begin
								Datapath.AluEn = 1'b1;
								Datapath.RegWe = 1'b1;
								Datapath.PcWe = 1'b1;
								Datapath.Rs1Sel = Rs1Rd;
							end
							LDW, STW: begin
								// Effective address computed ahead of the bus cycle
								Datapath.AluEn = 1'b1;
								Datapath.AluWe = 1'b1;
								Datapath.ImmSel = ImmShort;
							end
							PUSH: begin
								Datapath.AluEn = 1'b1;
								Datapath.AluWe = 1'b1;
								Datapath.RegWe = 1'b1; // New stack pointer
								Datapath.ImmSel = ImmShort;
								Datapath.Rs1Sel = Rs1Seven;
								Datapath.RwSel = RwSeven;
							end
							POP: begin
								Datapath.AluEn = 1'b1;
								Datapath.AluWe = 1'b1;
								Datapath.ImmSel = ImmShort;
								Datapath.Rs1Sel = Rs1Seven;
								Datapath.Op2Sel = Op2Zero;
							end
							BRANCH: begin
								Datapath.PcWe = 1'b1;
								case (Instr.branch)
									RET: begin
										Datapath.LrEn = 1'b1;
										Datapath.PcSel = PcSysbus;
									end
									JMP: begin
										Datapath.ImmSel = ImmShort;
										Datapath.PcSel = PcAluOut;
									end
									default: begin
										Datapath.AluEn = 1'b1;
										Datapath.Op1Sel = Op1Pc; // PC relative target
										if (BranchTaken) begin
											Datapath.PcSel = PcAluOut;
											Datapath.LrWe = Instr.branch == BWL;
											if (Instr.branch == BWL)
												Datapath.LrSel = LrPc;
										end
									end
								endcase
							end
							INTERRUPT: begin
								Datapath.PcEn = 1'b1;
								Datapath.PcWe = 1'b1;
								IntEnable = Instr.branch == intEnableCode;
								IntDisable = Instr.branch == intDisableCode;
							end
							default: ;
						endcase
					end
					cycle0: begin
						Datapath.AluEn = 1'b1;
						Datapath.ImmSel = ImmShort;
						if (Instr.opcode inside {PUSH, POP})
							Datapath.Rs1Sel = Rs1Seven;
					end
					cycle1: begin
						Datapath.AluEn = 1'b1;
						Datapath.Op2Sel = Op2Zero;
						Datapath.AluWe = Instr.opcode != POP; // Data passes through
						case (Instr.opcode)
							LDW, STW: Datapath.Rs1Sel = Rs1Rd;
							POP: Datapath.Rs1Sel = Rs1Seven;
							default: Datapath.Rs1Sel = Rs1Ra;
						endcase
					end
					cycle2: begin
						Datapath.PcWe = 1'b1;
						case (Instr.opcode)
							LDW: begin
								Datapath.RegWe = 1'b1;
								Datapath.WdSel = WdSys;
							end
							STW: begin
								Datapath.AluEn = 1'b1; // Hold store data
								Datapath.Op2Sel = Op2Zero;
							end
							PUSH: begin
								Datapath.AluEn = 1'b1;
								Datapath.AluWe = 1'b1;
								Datapath.Op2Sel = Op2Zero;
							end
							POP: begin
								Datapath.RegWe = nWait; // Write only once data is valid
								Datapath.Rs1Sel = Rs1Rd;
								Datapath.RwSel = RwRa;
								Datapath.WdSel = WdSys;
							end
							default: ;
						endcase
					end
					cycle3: begin
						case (Instr.opcode)
							LDW: Datapath.PcEn = 1'b1;
							STW, PUSH: begin
								Datapath.AluEn = 1'b1;
								Datapath.Op2Sel = Op2Zero;
							end
							POP: begin
								// Stack pointer write-back
								Datapath.RegWe = 1'b1;
								Datapath.ImmSel = ImmShort;
								Datapath.Rs1Sel = Rs1Seven;
								Datapath.RwSel = RwSeven;
							end
							default: ;
						endcase
					end
					default: ;
				endcase
			end
			interrupt: begin
				case (Phase.stateSub)
					cycle4: begin
						IntDisable = 1'b1; // No nesting
						Datapath.AluEn = 1'b1;
						Datapath.AluWe = 1'b1;
						Datapath.RegWe = 1'b1;
						Datapath.AluOr = SubOr;
						Datapath.Op2Sel = Op2Zero;
						Datapath.Rs1Sel = Rs1Seven;
						Datapath.RwSel = RwSeven;
					end
					cycle0: begin
						Datapath.AluEn = 1'b1;
						Datapath.AluOr = SubOr;
						Datapath.Op2Sel = Op2Zero;
						Datapath.Rs1Sel = Rs1Seven;
					end
					cycle1: begin
						Datapath.AluEn = 1'b1;
						Datapath.Op2Sel = Op2Zero;
					end
					cycle2: Datapath.PcEn = 1'b1; // Return address onto the bus
					cycle3: begin
						Datapath.PcEn = 1'b1;
						Datapath.PcWe = 1'b1;
						Datapath.PcSel = PcInt;
					end
					default: ;
				endcase
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- source/flagRegister.sv
// Status register and branch condition
`timescale 1ns/1ps
`default_nettype none

module flagRegister (
	input wire Clock,
	input wire nReset,
	input wire [controlPkg::flagWidth-1:0] Flags,
	input wire StatusWe,
	input wire controlPkg::instr_t Instr,
	output logic [controlPkg::flagWidth-1:0] StatusReg,
	output logic CFlag,
	output logic BranchTaken
);
	import controlPkg::*;

	logic lessThan;

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset)
			StatusReg <= '0;
		else if (StatusWe)
			StatusReg <= Flags; // ALU flags of the executing op
	end

	assign CFlag = StatusReg[flagC];

	// Signed less-than after a compare
	assign lessThan = StatusReg[flagN] ^ StatusReg[flagV];

	always_comb begin
		case (Instr.branch)
			BR, BWL: BranchTaken = 1'b1;
			BNE: BranchTaken = !StatusReg[flagZ];
			BE: BranchTaken = StatusReg[flagZ];
			BLT: BranchTaken = lessThan;
			BGE: BranchTaken = !lessThan;
			default: BranchTaken = 1'b0; // RET and JMP are not conditional
		endcase
	end

endmodule

`default_nettype wire

//--- source/interruptController.sv
// Interrupt request synchronizer and mask
`timescale 1ns/1ps
`default_nettype none

module interruptController (
	input wire Clock,
	input wire nReset,
	input wire nIRQ,
	input wire IntEnable,
	input wire IntDisable,
	output logic IntReq
);
	import controlPkg::*;

	logic irqSync1;
	logic irqSync2;
	logic intStatus; // Interrupts allowed

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			irqSync1 <= 1'b0;
			irqSync2 <= 1'b0;
			intStatus <= 1'b0;
		end else begin
			irqSync1 <= ~nIRQ; // Request is active low at the pin
			irqSync2 <= irqSync1;
			if (IntEnable)
				intStatus <= 1'b1;
			else if (IntDisable)
				intStatus <= 1'b0;
		end
	end

	assign IntReq = irqSync2 & intStatus;

	// EI and the interrupt entry come from different decoder states
	assert property (@(posedge Clock) disable iff (!nReset)
		!(IntEnable && IntDisable))
		else $error("Interrupt enable and disable pulsed together");

endmodule

`default_nettype wire

//--- source/memoryBusDecoder.sv
// Memory bus strobe decode
`timescale 1ns/1ps
`default_nettype none

module memoryBusDecoder (
	input wire controlPkg::phase_t Phase,
	input wire controlPkg::instr_t Instr,
	output controlPkg::busCtrl_t Bus
);
	import controlPkg::*;

	logic busCycle;
	logic isRead;
	logic isWrite;

	// Fetch, memory instructions and the interrupt entry use the bus
	assign busCycle = Phase.state == fetch || Phase.state == interrupt ||
		(Phase.state == execute && Instr.opcode inside {LDW, STW, PUSH, POP});
	assign isRead = Phase.state == fetch ||
		(Phase.state == execute && Instr.opcode inside {LDW, POP});
	assign isWrite = Phase.state == interrupt ||
		(Phase.state == execute && Instr.opcode inside {STW, PUSH});

	always_comb begin
		// Strobes idle inactive
		Bus = '{ALE: 1'b0, nME: 1'b1, nOE: 1'b1, nWE: 1'b1, MemEn: 1'b0, ENB: 1'b0};
		if (busCycle) begin
			case (Phase.stateSub)
				cycle0: Bus.ALE = 1'b1; // Address latch
				cycle1: Bus.nME = 1'b0;
				cycle2: begin
					Bus.nME = 1'b0;
					if (isRead) begin
						Bus.nOE = 1'b0;
						Bus.MemEn = 1'b1;
						Bus.ENB = 1'b1;
					end
				end
				cycle3: Bus.nWE = !isWrite; // Write after the select is released
				default: ;
			endcase
		end
	end

	// Checked on the settled strobes as each phase ends
	assert property (@(Phase) !(!Bus.nWE && !Bus.nOE))
		else $error("Read and write strobes overlap");

	assert property (@(Phase) !(Bus.ALE && !Bus.nME))
		else $error("Address latch during memory select");

endmodule

`default_nettype wire

//--- source/sequencer.sv
// Major state and sub-cycle sequencer
`timescale 1ns/1ps
`default_nettype none

module sequencer (
	input wire Clock,
	input wire nReset,
	input wire controlPkg::instr_t Instr,
	input wire nWait,
	input wire IntReq,
	output controlPkg::phase_t Phase
);
	import controlPkg::*;

	phase_t phaseNext;
	logic isMemory;
	logic endOfInstr;

	assign isMemory = Instr.opcode inside {LDW, STW, PUSH, POP};

	always_comb begin
		phaseNext = Phase;
		endOfInstr = 1'b0;
		case (Phase.stateSub)
			cycle0: phaseNext.stateSub = cycle1;
			cycle1: phaseNext.stateSub = cycle2;
			cycle2: begin
				// Memory stalls hold cycle2, the interrupt entry never waits
				if (nWait || Phase.state == interrupt)
					phaseNext.stateSub = cycle3;
			end
			cycle3: begin
				case (Phase.state)
					fetch: phaseNext = '{state: execute, stateSub: cycle4};
					execute: endOfInstr = 1'b1;
					default: phaseNext = '{state: fetch, stateSub: cycle0};
				endcase
			end
			cycle4: begin
				if (Phase.state == execute && !isMemory)
					endOfInstr = 1'b1; // Single-cycle op done
				else
					phaseNext.stateSub = cycle0;
			end
			default: phaseNext = '{state: fetch, stateSub: cycle0};
		endcase

		// EI, DI and the other INTERRUPT codes never take the request themselves
		if (endOfInstr) begin
			if (IntReq && Instr.opcode != INTERRUPT)
				phaseNext = '{state: interrupt, stateSub: cycle4};
			else
				phaseNext = '{state: fetch, stateSub: cycle0};
		end
	end

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset)
			Phase <= '{state: fetch, stateSub: cycle0};
		else
			Phase <= phaseNext;
	end

	assert property (@(posedge Clock) disable iff (!nReset)
		Phase.state == fetch |-> Phase.stateSub != cycle4)
		else $error("Fetch reached cycle4");

endmodule

`default_nettype wire

//--- tests/cpuControlTb.sv
// CPU control unit testbench
`timescale 1ns/1ps
`default_nettype none

module cpuControlTb;
	import controlPkg::*;

	typedef struct {
		opcode_t opcode;
		branch_t branch;
		bit statusWrite;   // ALU op or compare
		int stallMax;      // Longest nWait low run in cycle2
		logic irqLevel;
		int baseLen;       // 5 or 9 cycles
		pcSel_t pcSel;     // PcSel in execute cycle4
		logic lrWe;
	} row_t;

	logic Clock;
	logic nReset;
	instr_t Instr;
	logic [flagWidth-1:0] Flags;
	logic nIRQ;
	logic nWait;
	datapathCtrl_t Datapath;
	busCtrl_t Bus;
	logic [flagWidth-1:0] StatusReg;
	logic CFlag;

	row_t rows[$];
	int cycleCount = 0;
	int timeoutLimit = 1000;
	bit firstCycle;

	cpuControl i_cpuControl (
		.Clock(Clock), .nReset(nReset), .Instr(Instr), .Flags(Flags),
		.nIRQ(nIRQ), .nWait(nWait), .Datapath(Datapath), .Bus(Bus),
		.StatusReg(StatusReg), .CFlag(CFlag)
	);

	initial begin
		Clock = 1'b0;
		forever #50 Clock = ~Clock;
	end

	always @(posedge Clock) begin
		cycleCount++;
		if (cycleCount > timeoutLimit)
			failRun("Timeout, the instruction sequence never completed");
	end

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic checkBus(input string name, input busCtrl_t exp, input busCtrl_t act);
		if (act !== exp)
			failRun($sformatf("** Error %s: expected %h actual %h", name, exp, act));
	endtask

	// Only the fields set in mask are compared
	task automatic checkDatapath(input string name, input datapathCtrl_t exp,
		input datapathCtrl_t act, input datapathCtrl_t mask);
		if ((act & mask) !== (exp & mask))
			failRun($sformatf("** Error %s: expected %h actual %h", name, exp & mask, act & mask));
	endtask

	task automatic checkStatus(input string name, input logic [flagWidth-1:0] exp,
		input logic [flagWidth-1:0] act);
		if (act !== exp)
			failRun($sformatf("** Error %s: expected %h actual %h", name, exp, act));
	endtask

	task automatic checkPcSel(input string name, input pcSel_t exp, input pcSel_t act);
		if (act !== exp)
			failRun($sformatf("** Error %s: expected %s actual %s", name, exp.name(), act.name()));
	endtask

	task automatic checkBit(input string name, input logic exp, input logic act);
		if (act !== exp)
			failRun($sformatf("** Error %s: expected %b actual %b", name, exp, act));
	endtask

	task automatic checkCount(input string name, input int exp, input int act);
		if (act != exp)
			failRun($sformatf("** Error %s: expected %0d actual %0d", name, exp, act));
	endtask

	task automatic addRow(input opcode_t op, input branch_t br, input bit sw, input int stall,
		input logic irq, input int len, input pcSel_t pc, input logic lr);
		row_t r;
		r = '{opcode: op, branch: br, statusWrite: sw, stallMax: stall, irqLevel: irq,
			baseLen: len, pcSel: pc, lrWe: lr};
		rows.push_back(r);
	endtask

	// Branch rule on the status held during execute
	function automatic pcSel_t expectedPcSel(input row_t r, input logic [flagWidth-1:0] st);
		logic taken;
		if (r.opcode != BRANCH || !(r.branch inside {BNE, BE, BLT, BGE}))
			return r.pcSel;
		case (r.branch)
			BNE: taken = !st[flagZ];
			BE: taken = st[flagZ];
			BLT: taken = st[flagN] != st[flagV];
			default: taken = st[flagN] == st[flagV];
		endcase
		return taken ? PcAluOut : Pc1;
	endfunction

	task automatic nextCycle();
		if (firstCycle)
			firstCycle = 1'b0; // Reset was released inside this cycle
		else begin
			@(posedge Clock);
			#10;
		end
	endtask

	task automatic buildTable();
		addRow(ADD, BR, 1, 2, 1'b1, 5, Pc1, 1'b0);
		addRow(CMPI, BR, 1, 0, 1'b1, 5, Pc1, 1'b0);
		addRow(LUI, BR, 0, 1, 1'b1, 5, Pc1, 1'b0);
		addRow(LLI, BR, 0, 0, 1'b1, 5, Pc1, 1'b0);
		addRow(BRANCH, BR, 0, 0, 1'b1, 5, PcAluOut, 1'b0);
		addRow(SUB, BR, 1, 0, 1'b1, 5, Pc1, 1'b0);
		addRow(BRANCH, BNE, 0, 1, 1'b1, 5, Pc1, 1'b0);
		addRow(BRANCH, BE, 0, 0, 1'b1, 5, Pc1, 1'b0);
		addRow(BRANCH, BLT, 0, 0, 1'b1, 5, Pc1, 1'b0);
		addRow(BRANCH, BGE, 0, 2, 1'b1, 5, Pc1, 1'b0);
		addRow(BRANCH, BWL, 0, 0, 1'b1, 5, PcAluOut, 1'b1);
		addRow(BRANCH, RET, 0, 0, 1'b1, 5, PcSysbus, 1'b0);
		addRow(BRANCH, JMP, 0, 0, 1'b1, 5, PcAluOut, 1'b0);
		addRow(LDW, BR, 0, 3, 1'b1, 9, Pc1, 1'b0);
		addRow(STW, BR, 0, 3, 1'b1, 9, Pc1, 1'b0);
		addRow(PUSH, BR, 0, 2, 1'b1, 9, Pc1, 1'b0);
		addRow(POP, BR, 0, 3, 1'b1, 9, Pc1, 1'b0);
		addRow(INTERRUPT, BR, 0, 0, 1'b1, 5, Pc1, 1'b0);
		addRow(INTERRUPT, branch_t'(intEnableCode), 0, 0, 1'b0, 5, Pc1, 1'b0);
		addRow(ADD, BR, 1, 1, 1'b0, 5, Pc1, 1'b0);   // Takes the interrupt
		addRow(SUB, BR, 1, 0, 1'b0, 5, Pc1, 1'b0);   // Masked after entry
		addRow(INTERRUPT, branch_t'(intEnableCode), 0, 0, 1'b0, 5, Pc1, 1'b0);
		addRow(INTERRUPT, branch_t'(intDisableCode), 0, 0, 1'b0, 5, Pc1, 1'b0);
		addRow(PUSH, BR, 0, 1, 1'b0, 9, Pc1, 1'b0);
		addRow(ADD, BR, 1, 0, 1'b0, 5, Pc1, 1'b0);
	endtask

	initial begin
		busCtrl_t idleBus;
		datapathCtrl_t dpMask;
		logic [flagWidth-1:0] status;
		logic [flagWidth-1:0] flagsVal;
		logic irWeLast;
		bit intOn;
		bit entry;
		bit isMem;
		bit aleSeen;
		bit meSeen;
		bit enbSeen;
		int fs;
		int es;
		int total;
		int prevTotal;
		int prevRise;
		int nweLow;
		string name;
		row_t r;

		void'($urandom(32'h64f4));
		nReset = 1'b0;
		Instr = '{opcode: ADD, branch: BR};
		Flags = '0;
		nIRQ = 1'b1;
		nWait = 1'b1;
		buildTable();
		timeoutLimit = 20 * (rows.size() + 1) + 16;

		idleBus = '{ALE: 1'b1, nME: 1'b1, nOE: 1'b1, nWE: 1'b1, MemEn: 1'b0, ENB: 1'b0};
		dpMask = '0;
		dpMask.RegWe = 1'b1;
		dpMask.PcWe = 1'b1;
		dpMask.AluWe = 1'b1;
		dpMask.LrWe = 1'b1;

		repeat (15) @(posedge Clock);
		@(negedge Clock);
		checkBus("reset bus", idleBus, Bus);
		checkStatus("reset status", '0, StatusReg);
		checkDatapath("reset datapath", '0, Datapath, dpMask);
		@(posedge Clock);
		#10 nReset = 1'b1;
		firstCycle = 1'b1;

		status = '0;
		intOn = 1'b0;
		prevTotal = 0;
		prevRise = 0;
		irWeLast = 1'b0;
		foreach (rows[i]) begin
			r = rows[i];
			name = $sformatf("row %0d %s", i, r.opcode.name());
			isMem = r.opcode inside {LDW, STW, PUSH, POP};
			fs = r.stallMax > 0 ? int'($urandom_range(r.stallMax, 0)) : 0;
			es = isMem ? int'($urandom_range(r.stallMax, 0)) : 0;
			flagsVal = 4'($urandom_range(15, 0));
			entry = intOn && !r.irqLevel && r.opcode != INTERRUPT;
			total = r.baseLen + fs + es + (entry ? 5 : 0);
			nweLow = 0;
			aleSeen = 0;
			meSeen = 0;
			enbSeen = 0;
			for (int k = 0; k < total; k++) begin
				nextCycle();
				Instr = '{opcode: r.opcode, branch: r.branch};
				Flags = flagsVal;
				nIRQ = r.irqLevel;
				nWait = !((k >= 2 && k < 2 + fs) || (isMem && k >= 7 + fs && k < 7 + fs + es));
				@(negedge Clock);
				if (k == 0) begin
					checkBus({name, " fetch bus"}, idleBus, Bus);
					checkStatus({name, " status"}, status, StatusReg);
					checkBit({name, " CFlag"}, status[flagC], CFlag);
				end
				// Length runs from one IrWe rise of the DUT to the next
				if (Datapath.IrWe && !irWeLast) begin
					if (prevRise > 0)
						checkCount({name, " length"}, prevTotal, cycleCount - prevRise);
					prevRise = cycleCount;
				end
				irWeLast = Datapath.IrWe;
				checkBit($sformatf("%s IrWe cycle %0d", name, k), k >= 2 && k <= 2 + fs,
					Datapath.IrWe);
				if (k == 4 + fs) begin
					checkPcSel({name, " PcSel"}, expectedPcSel(r, status), Datapath.PcSel);
					checkBit({name, " LrWe"}, r.lrWe, Datapath.LrWe);
				end
				if (!Bus.nWE) begin
					nweLow++;
					if (r.opcode == STW && !(aleSeen && meSeen))
						failRun({name, ": write strobe came before address and select"});
				end
				if (Bus.ENB && !Bus.nWE)
					failRun({name, ": read enable with write strobe low"});
				if (k > 4 + fs) begin
					aleSeen |= Bus.ALE;
					meSeen |= !Bus.nME;
					enbSeen |= Bus.ENB;
				end
				if (entry && k == total - 1) begin
					checkPcSel({name, " interrupt PcSel"}, PcInt, Datapath.PcSel);
					checkBit({name, " interrupt PcWe"}, 1'b1, Datapath.PcWe);
				end
			end
			checkCount({name, " write strobes"},
				(r.opcode inside {STW, PUSH} ? 1 : 0) + (entry ? 1 : 0), nweLow);
			if (r.opcode inside {LDW, POP} && !enbSeen)
				failRun({name, ": no read enable in the memory cycle"});
			if (r.statusWrite)
				status = flagsVal;
			if (entry)
				intOn = 1'b0;
			if (r.opcode == INTERRUPT && r.branch == branch_t'(intEnableCode))
				intOn = 1'b1;
			if (r.opcode == INTERRUPT && r.branch == branch_t'(intDisableCode))
				intOn = 1'b0;
			prevTotal = total;
		end

		nextCycle();
		@(negedge Clock);
		checkStatus("final status", status, StatusReg);
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire
